// ==== design/csr_pkg.sv ====
package csr_pkg;

    // operation codes as seen on the op port
    typedef enum logic [2:0] {
        OP_EXCEPTION = 3'd0,
        OP_MRET      = 3'd1,
        OP_CSRRW     = 3'd5,
        OP_CSRRS     = 3'd6,
        OP_CSRRC     = 3'd7
    } csr_op_e;

    typedef enum logic [2:0] {
        SEL_MSTATUS = 3'd0, // 0x300
        SEL_MIE     = 3'd1, // 0x304
        SEL_MTVEC   = 3'd2, // 0x305
        SEL_MEPC    = 3'd3, // 0x341
        SEL_MCAUSE  = 3'd4, // 0x342
        SEL_MIP     = 3'd5, // 0x344
        SEL_NONE    = 3'd6
    } csr_sel_e;

    localparam logic [11:0] ADDR_MSTATUS = 12'h300;
    localparam logic [11:0] ADDR_MIE     = 12'h304;
    localparam logic [11:0] ADDR_MTVEC   = 12'h305;
    localparam logic [11:0] ADDR_MEPC    = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE  = 12'h342;
    localparam logic [11:0] ADDR_MIP     = 12'h344;

    // bit positions inside the register images
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MSIE_BIT     = 3;
    localparam int MIE_MEIE_BIT     = 11;
    localparam int MIP_MSIP_BIT     = 3;
    localparam int MIP_MEIP_BIT     = 11;

    typedef enum logic [1:0] {
        SEQ_IDLE = 2'b00,
        SEQ_BUSY = 2'b01,
        SEQ_DONE = 2'b10
    } seq_state_e;

    typedef struct packed {
        csr_op_e     op;
        csr_sel_e    sel;
        logic        writes;  // op really modifies the target
        logic        illegal;
        logic [31:0] wdata;
        logic [4:0]  cause;   // {irq, code}
    } csr_cmd_t;

    typedef struct packed {
        logic        mie;
        logic        mpie;
        logic        meie;
        logic        msie;
        logic        meip;
        logic        msip;
        logic [31:0] mepc;
        logic [3:0]  mcause_code;
        logic        mcause_irq;
    } csr_state_t;

endpackage

// ==== design/csr_decode.sv ====
`timescale 1ns/1ps

module csr_decode
    import csr_pkg::*;
(
    input  logic [2:0]  op,
    input  logic [11:0] addr_exception,
    input  logic [31:0] write_value,
    output csr_cmd_t    cmd
);

    logic op_known;
    logic op_csr;
    logic sel_readonly;

    always_comb begin
        cmd.op = csr_op_e'(op);
        cmd.wdata = write_value;
        cmd.cause = addr_exception[4:0]; // only meaningful for exceptions

        case (addr_exception)
            ADDR_MSTATUS: cmd.sel = SEL_MSTATUS;
            ADDR_MIE:     cmd.sel = SEL_MIE;
            ADDR_MTVEC:   cmd.sel = SEL_MTVEC;
            ADDR_MEPC:    cmd.sel = SEL_MEPC;
            ADDR_MCAUSE:  cmd.sel = SEL_MCAUSE;
            ADDR_MIP:     cmd.sel = SEL_MIP;
            default:      cmd.sel = SEL_NONE;
        endcase

        case (op)
            OP_EXCEPTION, OP_MRET: begin
                op_known = 1'b1;
                op_csr = 1'b0;
            end
            OP_CSRRW, OP_CSRRS, OP_CSRRC: begin
                op_known = 1'b1;
                op_csr = 1'b1;
            end
            default: begin
                op_known = 1'b0;
                op_csr = 1'b0;
            end
        endcase

        // set/clear with a zero mask is a pure read
        case (op)
            OP_CSRRW:           cmd.writes = 1'b1;
            OP_CSRRS, OP_CSRRC: cmd.writes = (write_value != 32'b0);
            default:            cmd.writes = 1'b0;
        endcase

        sel_readonly = (cmd.sel == SEL_MTVEC) ||
                       (cmd.sel == SEL_MEPC) ||
                       (cmd.sel == SEL_MCAUSE);

        cmd.illegal = !op_known ||
                      (op_csr && cmd.sel == SEL_NONE) ||
                      (op_csr && cmd.writes && sel_readonly);
    end

endmodule

// ==== design/csr_sequencer.sv ====
`timescale 1ns/1ps

module csr_sequencer
    import csr_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic available,
    output logic busy,
    output logic execute
);

    seq_state_e state_q;
    seq_state_e state_d;
    logic       busy_d;

    always_comb begin
        state_d = state_q;
        busy_d = 1'b0;
        case (state_q)
            SEQ_IDLE: begin
                if (available) begin
                    state_d = SEQ_BUSY;
                    busy_d = 1'b1;
                end
            end
            SEQ_BUSY: begin
                state_d = SEQ_DONE; // op completes on this edge
            end
            SEQ_DONE: begin
                busy_d = available; // hold off a requester that keeps available up
                if (!available) begin
                    state_d = SEQ_IDLE;
                end
            end
            default: begin
                state_d = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= SEQ_IDLE;
            busy <= 1'b0;
        end else begin
            state_q <= state_d;
            busy <= busy_d;
        end
    end

    assign execute = (state_q == SEQ_BUSY);

    a_execute_single: assert property (@(posedge clk) disable iff (reset)
        execute |=> !execute);

endmodule

// ==== design/csr_regs.sv ====
`timescale 1ns/1ps

module csr_regs
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       execute,
    input  logic       ext_irq,
    input  csr_cmd_t   cmd,
    output csr_state_t state
);

    // write / set / clear on a single bit
    function automatic logic apply_bit(input csr_op_e op, input logic old_bit,
                                       input logic wbit);
        case (op)
            OP_CSRRW: apply_bit = wbit;
            OP_CSRRS: apply_bit = old_bit | wbit;
            OP_CSRRC: apply_bit = old_bit & ~wbit;
            default:  apply_bit = old_bit;
        endcase
    endfunction

    logic update;

    assign update = execute && !cmd.illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '0;
        end else begin
            state.meip <= ext_irq; // pending line is not software writable

            if (update) begin
                case (cmd.op)
                    OP_EXCEPTION: begin
                        state.mcause_code <= cmd.cause[3:0];
                        state.mcause_irq <= cmd.cause[4];
                        state.mepc <= cmd.wdata; // trapping pc
                        state.mpie <= state.mie;
                        state.mie <= 1'b0;
                    end
                    OP_MRET: begin
                        state.mie <= state.mpie;
                    end
                    OP_CSRRW, OP_CSRRS, OP_CSRRC: begin
                        if (cmd.writes) begin
                            case (cmd.sel)
                                SEL_MSTATUS: begin
                                    state.mie <= apply_bit(cmd.op, state.mie,
                                                           cmd.wdata[MSTATUS_MIE_BIT]);
                                    state.mpie <= apply_bit(cmd.op, state.mpie,
                                                            cmd.wdata[MSTATUS_MPIE_BIT]);
                                end
                                SEL_MIE: begin
                                    state.msie <= apply_bit(cmd.op, state.msie,
                                                            cmd.wdata[MIE_MSIE_BIT]);
                                    state.meie <= apply_bit(cmd.op, state.meie,
                                                            cmd.wdata[MIE_MEIE_BIT]);
                                end
                                SEL_MIP: begin
                                    state.msip <= apply_bit(cmd.op, state.msip,
                                                            cmd.wdata[MIP_MSIP_BIT]);
                                end
                                default: begin
                                    // read-only targets never get here
                                end
                            endcase
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // mepc is only written by trap entry
    a_mepc_trap_only: assert property (@(posedge clk) disable iff (reset)
        (state.mepc != $past(state.mepc)) |->
            $past(execute && cmd.op == OP_EXCEPTION));

endmodule

// ==== design/csr_result.sv ====
`timescale 1ns/1ps

module csr_result
    import csr_pkg::*;
#(
    parameter logic [31:0] irq_handler_addr = 32'h0000_0010
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        execute,
    input  csr_cmd_t    cmd,
    input  csr_state_t  state,
    output logic [31:0] read_value,
    output logic        fault
);

    logic [31:0] rdata;
    logic [31:0] mtvec_image;

    assign mtvec_image = {irq_handler_addr[31:2], 2'b00}; // direct mode only

    // old register image before this op updates anything
    always_comb begin
        rdata = 32'b0;
        case (cmd.op)
            OP_EXCEPTION: begin
                rdata = mtvec_image;
            end
            OP_MRET: begin
                rdata = state.mepc;
            end
            OP_CSRRW, OP_CSRRS, OP_CSRRC: begin
                case (cmd.sel)
                    SEL_MSTATUS: begin
                        rdata[MSTATUS_MIE_BIT] = state.mie;
                        rdata[MSTATUS_MPIE_BIT] = state.mpie;
                    end
                    SEL_MIE: begin
                        rdata[MIE_MSIE_BIT] = state.msie;
                        rdata[MIE_MEIE_BIT] = state.meie;
                    end
                    SEL_MTVEC:  rdata = mtvec_image;
                    SEL_MEPC:   rdata = state.mepc;
                    SEL_MCAUSE: rdata = {state.mcause_irq, 27'b0, state.mcause_code};
                    SEL_MIP: begin
                        rdata[MIP_MSIP_BIT] = state.msip;
                        rdata[MIP_MEIP_BIT] = state.meip;
                    end
                    default:    rdata = 32'b0; // unknown csr
                endcase
            end
            default: begin
                rdata = 32'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            read_value <= 32'b0;
            fault <= 1'b0;
        end else begin
            if (execute) begin
                read_value <= rdata; // held until the next op
            end
            fault <= execute && cmd.illegal; // single cycle pulse
        end
    end

    a_fault_pulse: assert property (@(posedge clk) disable iff (reset)
        fault |=> !fault);

endmodule

// ==== design/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*;
#(
    parameter logic [31:0] irq_handler_addr = 32'h0000_0010
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        available,
    input  logic [2:0]  op,
    input  logic [11:0] addr_exception,
    input  logic [31:0] write_value,
    input  logic        ext_irq,
    output logic [31:0] read_value,
    output logic        busy,
    output logic        fault
);

    csr_cmd_t   cmd;
    csr_state_t state;
    logic       execute;

    csr_decode u_decode (
        .op             (op),
        .addr_exception (addr_exception),
        .write_value    (write_value),
        .cmd            (cmd)
    );

    csr_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .available (available),
        .busy      (busy),
        .execute   (execute)
    );

    csr_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .execute (execute),
        .ext_irq (ext_irq),
        .cmd     (cmd),
        .state   (state)
    );

    csr_result #(
        .irq_handler_addr (irq_handler_addr)
    ) u_result (
        .clk        (clk),
        .reset      (reset),
        .execute    (execute),
        .cmd        (cmd),
        .state      (state),   // sampled before the regs update
        .read_value (read_value),
        .fault      (fault)
    );

endmodule

// ==== tests/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

    localparam logic [31:0] HANDLER = 32'h0000_0a44;
    localparam int OP_COUNT = 59; // ops issued over all tests
    localparam int CYCLE_LIMIT = OP_COUNT * 6 + 100;

    localparam logic [2:0] EXC_OP = 3'd0;
    localparam logic [2:0] MRET_OP = 3'd1;
    localparam logic [2:0] RW_OP = 3'd5;
    localparam logic [2:0] RS_OP = 3'd6;
    localparam logic [2:0] RC_OP = 3'd7;

    logic        clk;
    logic        reset;
    logic        available;
    logic [2:0]  op;
    logic [11:0] addr_exception;
    logic [31:0] write_value;
    logic        ext_irq;
    logic [31:0] read_value;
    logic        busy;
    logic        fault;

    // reference model of the architectural state
    logic        m_mie;
    logic        m_mpie;
    logic        m_meie;
    logic        m_msie;
    logic        m_msip;
    logic        m_irq;
    logic [31:0] m_mepc;
    logic [3:0]  m_code;

    logic [31:0] last_read;
    logic        last_fault;
    logic        fault_after;
    int          rise_cycles;
    int          done_cycles;
    integer      seed = 32'h59f2;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          cycle_count = 0;

    csr_unit #(
        .irq_handler_addr (HANDLER)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .available      (available),
        .op             (op),
        .addr_exception (addr_exception),
        .write_value    (write_value),
        .ext_irq        (ext_irq),
        .read_value     (read_value),
        .busy           (busy),
        .fault          (fault)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [11:0] pick_addr(input int idx);
        case (idx)
            0:       return 12'h300; // mstatus
            1:       return 12'h304; // mie
            2:       return 12'h344; // mip
            3:       return 12'h305; // mtvec
            4:       return 12'h341; // mepc
            default: return 12'h342; // mcause
        endcase
    endfunction

    function automatic logic [31:0] model_image(input logic [11:0] addr);
        logic [31:0] img;
        img = 32'b0;
        case (addr)
            12'h300: begin
                img[3] = m_mie;
                img[7] = m_mpie;
            end
            12'h304: begin
                img[3] = m_msie;
                img[11] = m_meie;
            end
            12'h344: begin
                img[3] = m_msip;
                img[11] = ext_irq; // pending line held long before any read
            end
            12'h305: img = HANDLER & ~32'h3;
            12'h341: img = m_mepc;
            12'h342: img = {m_irq, 27'b0, m_code};
            default: img = 32'b0;
        endcase
        return img;
    endfunction

    function automatic logic rule_bit(input logic [2:0] code, input logic old_bit,
                                      input logic wbit);
        if (code == RW_OP) return wbit;
        if (code == RS_OP) return old_bit | wbit;
        return old_bit & ~wbit;
    endfunction

    task automatic update_model(input logic [2:0] code, input logic [11:0] addr,
                                input logic [31:0] wval);
        if (code == RW_OP || wval != 32'b0) begin
            case (addr)
                12'h300: begin
                    m_mie = rule_bit(code, m_mie, wval[3]);
                    m_mpie = rule_bit(code, m_mpie, wval[7]);
                end
                12'h304: begin
                    m_msie = rule_bit(code, m_msie, wval[3]);
                    m_meie = rule_bit(code, m_meie, wval[11]);
                end
                12'h344: m_msip = rule_bit(code, m_msip, wval[3]);
                default: ;
            endcase
        end
    endtask

    task automatic trap_model(input logic [31:0] pc, input logic [4:0] cause);
        m_mepc = pc;
        m_code = cause[3:0];
        m_irq = cause[4];
        m_mpie = m_mie;
        m_mie = 1'b0;
    endtask

    task automatic do_op(input logic [2:0] code, input logic [11:0] addr,
                         input logic [31:0] wval);
        @(posedge clk);
        available <= 1'b1;
        op <= code;
        addr_exception <= addr;
        write_value <= wval;
        rise_cycles = 0;
        do begin
            @(negedge clk);
            rise_cycles++;
        end while (!busy);
        done_cycles = 0;
        do begin
            @(negedge clk);
            done_cycles++;
        end while (busy);
        last_read = read_value;
        last_fault = fault;
        @(posedge clk);
        available <= 1'b0;
        @(negedge clk);
        fault_after = fault;
        compare_word("fault one cycle later", fault_after, 0);
        while (busy) @(negedge clk);
    endtask

    // read through a zero set mask and compare with the model
    task automatic read_check(input logic [11:0] addr);
        logic [31:0] exp;
        exp = model_image(addr);
        do_op(RS_OP, addr, 32'b0);
        compare_word($sformatf("read_value csr 0x%03h", addr), last_read, exp);
        compare_word("fault", last_fault, 0);
    endtask

    task automatic finish_test(input string name, input int start);
        tests_run++;
        if (errors == start) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - start);
    endtask

    task automatic reset_and_timing();
        int start;
        start = errors;
        @(negedge clk);
        compare_word("busy", busy, 0);
        compare_word("fault", fault, 0);
        compare_word("read_value", read_value, 0);
        read_check(pick_addr(0));
        compare_word("cycles to busy", rise_cycles, 2);
        compare_word("cycles to result", done_cycles, 1);
        read_check(pick_addr(1));
        read_check(pick_addr(2));
        finish_test("reset_and_timing", start);
    endtask

    task automatic csr_set_clear_write();
        int start;
        logic [31:0] wval;
        logic [31:0] exp;
        logic [2:0] code;
        start = errors;
        for (int round = 0; round < 2; round++) begin
            for (int r = 0; r < 3; r++) begin
                for (int o = 0; o < 3; o++) begin
                    wval = $random(seed);
                    code = RW_OP + 3'(o);
                    exp = model_image(pick_addr(r));
                    do_op(code, pick_addr(r), wval);
                    compare_word("read_value", last_read, exp);
                    compare_word("fault", last_fault, 0);
                    update_model(code, pick_addr(r), wval);
                end
            end
        end
        for (int r = 0; r < 3; r++) read_check(pick_addr(r));
        finish_test("csr_set_clear_write", start);
    endtask

    task automatic trap_and_return();
        int start;
        logic [31:0] pc;
        logic [4:0] cause;
        start = errors;
        pc = $random(seed);
        pc[1:0] = 2'b00;
        cause = $random(seed);
        do_op(RS_OP, pick_addr(0), 32'h8); // enable interrupts first
        update_model(RS_OP, pick_addr(0), 32'h8);
        do_op(EXC_OP, {7'b0, cause}, pc);
        compare_word("read_value", last_read, HANDLER & ~32'h3);
        compare_word("fault", last_fault, 0);
        trap_model(pc, cause);
        read_check(pick_addr(0));
        read_check(pick_addr(5));
        read_check(pick_addr(4));
        do_op(MRET_OP, 12'h000, 32'b0);
        compare_word("read_value", last_read, pc);
        compare_word("fault", last_fault, 0);
        m_mie = m_mpie;
        read_check(pick_addr(0));
        finish_test("trap_and_return", start);
    endtask

    task automatic fault_cases();
        int start;
        logic [31:0] exp;
        start = errors;
        for (int i = 3; i < 6; i++) begin
            exp = model_image(pick_addr(i));
            do_op(RW_OP, pick_addr(i), $random(seed)); // read-only target
            compare_word("read_value", last_read, exp);
            compare_word("fault", last_fault, 1);
            read_check(pick_addr(i));
            do_op(RC_OP, pick_addr(i), 32'b0);
            compare_word("read_value", last_read, exp);
            compare_word("fault", last_fault, 0);
        end
        do_op(RS_OP, 12'h7c0, 32'h8); // no such csr
        compare_word("read_value", last_read, 0);
        compare_word("fault", last_fault, 1);
        do_op(RW_OP, 12'h123, $random(seed));
        compare_word("read_value", last_read, 0);
        compare_word("fault", last_fault, 1);
        for (int code = 2; code < 5; code++) begin
            do_op(3'(code), pick_addr(0), 32'hffff_ffff);
            compare_word("read_value", last_read, 0);
            compare_word("fault", last_fault, 1);
        end
        read_check(pick_addr(0));
        read_check(pick_addr(1));
        finish_test("fault_cases", start);
    endtask

    task automatic external_irq_line();
        int start;
        logic [31:0] exp;
        start = errors;
        @(posedge clk);
        ext_irq <= 1'b1;
        repeat (2) @(posedge clk);
        read_check(pick_addr(2));
        compare_word("read_value[11]", last_read[11], 1);
        exp = model_image(pick_addr(2));
        do_op(RW_OP, pick_addr(2), 32'h0000_0008);
        compare_word("read_value", last_read, exp);
        update_model(RW_OP, pick_addr(2), 32'h0000_0008);
        read_check(pick_addr(2));
        exp = model_image(pick_addr(2));
        do_op(RC_OP, pick_addr(2), 32'h0000_0808);
        compare_word("read_value", last_read, exp);
        update_model(RC_OP, pick_addr(2), 32'h0000_0808);
        read_check(pick_addr(2));
        compare_word("read_value[11]", last_read[11], 1);
        @(posedge clk);
        ext_irq <= 1'b0;
        repeat (2) @(posedge clk);
        read_check(pick_addr(2));
        finish_test("external_irq_line", start);
    endtask

    task automatic held_available();
        int start;
        logic [31:0] pc;
        start = errors;
        pc = $random(seed);
        pc[1:0] = 2'b00;
        do_op(RW_OP, pick_addr(0), 32'h8); // mie=1 mpie=0 tells one trap from two
        update_model(RW_OP, pick_addr(0), 32'h8);
        @(posedge clk);
        available <= 1'b1;
        op <= EXC_OP;
        addr_exception <= 12'h00b;
        write_value <= pc;
        do begin
            @(negedge clk);
        end while (!busy);
        do begin
            @(negedge clk);
        end while (busy);
        compare_word("read_value", read_value, HANDLER & ~32'h3);
        compare_word("fault", fault, 0);
        trap_model(pc, 5'h0b);
        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            compare_word("busy", busy, 1);
            compare_word("read_value", read_value, HANDLER & ~32'h3);
            compare_word("fault", fault, 0);
        end
        @(posedge clk);
        available <= 1'b0;
        do begin
            @(negedge clk);
        end while (busy);
        read_check(pick_addr(0));
        read_check(pick_addr(4));
        do_op(MRET_OP, 12'h000, 32'b0);
        compare_word("read_value", last_read, pc);
        m_mie = m_mpie;
        read_check(pick_addr(0));
        finish_test("held_available", start);
    endtask

    initial begin
        reset = 1'b1;
        available = 1'b0;
        op = 3'b0;
        addr_exception = 12'b0;
        write_value = 32'b0;
        ext_irq = 1'b0;
        {m_mie, m_mpie, m_meie, m_msie, m_msip, m_irq} = 6'b0;
        m_mepc = 32'b0;
        m_code = 4'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        reset_and_timing();
        csr_set_clear_write();
        trap_and_return();
        fault_cases();
        external_irq_line();
        held_available();
        $display("tests: %0d  checks: %0d  errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/csr_pkg.sv
design/csr_decode.sv
design/csr_sequencer.sv
design/csr_regs.sv
design/csr_result.sv
design/csr_unit.sv
tests/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - design/csr_pkg.sv
  - design/csr_decode.sv
  - design/csr_sequencer.sv
  - design/csr_regs.sv
  - design/csr_result.sv
  - design/csr_unit.sv
  - target: test
    files:
      - tests/csr_unit_tb.sv
